/* src/pingpong_pkg.sv */
// buffer sizes, pixel and address types, bank select type and fill state enum for the ping-pong buffer

package pingpong_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////
  localparam int BUF_DEPTH = 768;  // pixels per bank
  localparam int ADDR_W    = 10;   // covers up to 1024 words
  localparam int PIX_W     = 8;    // one grayscale pixel
  localparam int NUM_BANKS = 2;    // ping and pong

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////
  typedef logic [PIX_W-1:0]  pix_t;       // pixel value
  typedef logic [ADDR_W-1:0] addr_t;      // bank address or fill count
  typedef logic [0:0]        bank_sel_t;  // bank 0 or bank 1

  // fill controller states
  typedef enum logic {
    FILL_ACTIVE = 1'b0,  // still taking pixels
    FILL_DONE   = 1'b1   // bank full, extra pixels ignored
  } fill_state_e;

endpackage : pingpong_pkg

/* src/bank_if.sv */
// interface bundling one bank's write port and read port, with bank, fill and drain modports
`timescale 1ns/1ps

interface bank_if;
  import pingpong_pkg::*;

  // write side, owned by the fill controller
  logic  we;     // write strobe
  addr_t waddr;  // write address
  pix_t  wdata;  // pixel to store

  // read side, owned by the drain reader
  logic  re;     // read launch
  addr_t raddr;  // read address
  pix_t  rdata;  // registered read word

  modport bank_mp (
    input  we, waddr, wdata,
    input  re, raddr,
    output rdata
  );

  modport fill_mp (
    output we, waddr, wdata
  );

  modport drain_mp (
    output re, raddr,
    input  rdata
  );

endinterface : bank_if

/* src/input_pre_sram.sv */
// single BUF_DEPTH-word pixel bank with one write port and one registered read port
`timescale 1ns/1ps

module input_pre_sram (
  input logic   i_clk_input,  // single system clock
  bank_if.bank_mp bank        // write and read signals of this bank
);
  import pingpong_pkg::*;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////
  pix_t mem [BUF_DEPTH];  // no reset on contents

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////
  // the controller only ever drives addresses below BUF_DEPTH
  always_ff @(posedge i_clk_input) begin
    if (bank.we) begin
      mem[bank.waddr] <= bank.wdata;  // store at edge
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////
  // one cycle latency and rdata holds between reads
  always_ff @(posedge i_clk_input) begin
    if (bank.re) begin
      bank.rdata <= mem[bank.raddr];  // registered read
    end
  end

endmodule : input_pre_sram

/* src/pingpong_fill_ctrl.sv */
// write counter, fill FSM, bank select toggle and buffer ready flag
`timescale 1ns/1ps

module pingpong_fill_ctrl (
  input  logic                    i_clk_input,        // system clock
  input  logic                    i_rst_n,            // sync reset, active low
  input  logic                    i_en,               // global enable
  input  logic                    i_switch_pingpong,  // one-cycle swap strobe
  input  pingpong_pkg::pix_t      i_data_din,         // incoming pixel
  input  logic                    i_data_din_vld,     // pixel qualifier
  bank_if.fill_mp                 banks [pingpong_pkg::NUM_BANKS],  // write side of every bank
  output pingpong_pkg::bank_sel_t o_fill_bank,        // bank being filled
  output logic                    o_pl_buffer_ready   // fill bank full
);
  import pingpong_pkg::*;

  ////////////////////////////////////////
  // control state
  ////////////////////////////////////////
  fill_state_e state_q;    // fill FSM
  addr_t       fill_cnt;   // next write address
  addr_t       cnt_nxt;    // count after this write
  logic        sw_fire;    // swap this cycle
  logic        wr_fire;    // pixel accepted this cycle

  // switch beats a pixel in the same cycle
  assign sw_fire = i_en && i_switch_pingpong;
  assign wr_fire = i_en && i_data_din_vld && !i_switch_pingpong
                   && (state_q == FILL_ACTIVE);
  assign cnt_nxt = fill_cnt + addr_t'(1);  // never wraps as the FSM stops at depth

  ////////////////////////////////////////
  // FSM, counter, bank select
  ////////////////////////////////////////
  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      state_q           <= FILL_ACTIVE;
      fill_cnt          <= '0;
      o_fill_bank       <= '0;  // start on bank 0
      o_pl_buffer_ready <= 1'b0;
    end else begin
      o_pl_buffer_ready <= (state_q == FILL_DONE);  // one edge behind state
      if (sw_fire) begin
        o_fill_bank <= ~o_fill_bank;  // drained bank becomes fill bank
        fill_cnt    <= '0;
        state_q     <= FILL_ACTIVE;
      end else begin
        case (state_q)
          FILL_ACTIVE: begin
            if (wr_fire) begin
              fill_cnt <= cnt_nxt;  // advance with the write
              if (cnt_nxt == addr_t'(BUF_DEPTH)) begin
                state_q <= FILL_DONE;  // last word landed
              end
            end
          end
          FILL_DONE: begin
            state_q <= FILL_DONE;  // park until next swap
          end
          default: begin
            state_q <= FILL_ACTIVE;
          end
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // bank write ports
  ////////////////////////////////////////
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_wr
    assign banks[b].we    = wr_fire && (o_fill_bank == bank_sel_t'(b));  // only fill bank
    assign banks[b].waddr = fill_cnt;    // same address to both
    assign banks[b].wdata = i_data_din;  // same data to both
  end

endmodule : pingpong_fill_ctrl

/* src/pingpong_drain_reader.sv */
// read router to the drained bank with range check, select pipeline and output register
`timescale 1ns/1ps

module pingpong_drain_reader (
  input  logic                    i_clk_input,  // system clock
  input  logic                    i_rst_n,      // sync reset, active low
  input  logic                    i_en,         // global enable
  input  pingpong_pkg::addr_t     i_conv_addr,  // engine read address
  input  pingpong_pkg::bank_sel_t i_fill_bank,  // bank being written
  bank_if.drain_mp                banks [pingpong_pkg::NUM_BANKS],  // read side of every bank
  output pingpong_pkg::pix_t      o_conv_dout   // two-cycle read result
);
  import pingpong_pkg::*;

  ////////////////////////////////////////
  // issue stage
  ////////////////////////////////////////
  bank_sel_t drain_bank;               // the other bank
  logic      in_range;                 // addr below depth
  pix_t      bank_rdata [NUM_BANKS];   // gathered rdata

  assign drain_bank = ~i_fill_bank;
  assign in_range   = (i_conv_addr < addr_t'(BUF_DEPTH));

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_rd
    // out of range addresses never touch the array
    assign banks[b].re    = i_en && in_range && (drain_bank == bank_sel_t'(b));
    assign banks[b].raddr = i_conv_addr;
    assign bank_rdata[b]  = banks[b].rdata;
  end

  ////////////////////////////////////////
  // pipeline and output register
  ////////////////////////////////////////
  bank_sel_t sel_q;    // bank chosen at issue
  logic      range_q;  // range flag at issue
  logic      vld_q;    // a read was launched

  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      sel_q       <= '0;
      range_q     <= 1'b0;
      vld_q       <= 1'b0;
      o_conv_dout <= '0;
    end else begin
      sel_q   <= drain_bank;  // immune to a later swap
      range_q <= in_range;
      vld_q   <= i_en;
      if (vld_q) begin
        o_conv_dout <= range_q ? bank_rdata[sel_q] : '0;  // zero past depth
      end
    end
  end

endmodule : pingpong_drain_reader

/* src/pingpong_buffer.sv */
// top level with bank interfaces, generated banks, fill controller and drain reader
`timescale 1ns/1ps

module pingpong_buffer (
  input  logic                i_clk_input,        // single system clock
  input  logic                i_rst_n,            // sync reset, active low
  input  logic                i_en,               // global enable
  //////////////////////////////////////
  input  logic                i_switch_pingpong,  // one-cycle swap strobe
  //////////////////////////////////////
  input  pingpong_pkg::pix_t  i_data_din,         // producer pixel
  input  logic                i_data_din_vld,     // pixel strobe
  output logic                o_pl_buffer_ready,  // fill bank full
  //////////////////////////////////////
  input  pingpong_pkg::addr_t i_conv_addr,        // engine read address
  output pingpong_pkg::pix_t  o_conv_dout         // engine read data
);
  import pingpong_pkg::*;

  ////////////////////////////////////////
  // bank buses
  ////////////////////////////////////////
  bank_if    bank_bus [NUM_BANKS] ();  // one bundle per bank
  bank_sel_t fill_bank;                // controller to reader

  ////////////////////////////////////////
  // storage banks
  ////////////////////////////////////////
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    input_pre_sram u_bank (
      .i_clk_input (i_clk_input),
      .bank        (bank_bus[g].bank_mp)
    );
  end

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////
  pingpong_fill_ctrl u_fill (
    .i_clk_input       (i_clk_input),
    .i_rst_n           (i_rst_n),
    .i_en              (i_en),
    .i_switch_pingpong (i_switch_pingpong),
    .i_data_din        (i_data_din),
    .i_data_din_vld    (i_data_din_vld),
    .banks             (bank_bus),          // fill modport of each
    .o_fill_bank       (fill_bank),
    .o_pl_buffer_ready (o_pl_buffer_ready)
  );

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////
  pingpong_drain_reader u_drain (
    .i_clk_input (i_clk_input),
    .i_rst_n     (i_rst_n),
    .i_en        (i_en),
    .i_conv_addr (i_conv_addr),
    .i_fill_bank (fill_bank),   // reads go to the other bank
    .banks       (bank_bus),    // drain modport of each
    .o_conv_dout (o_conv_dout)
  );

endmodule : pingpong_buffer

/* verification/tb_clk_gen.sv */
// free-running 10 ns testbench clock
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk  // testbench clock
);
  localparam int HALF_PERIOD_NS = 5;  // 10 ns period

  initial o_clk = 1'b0;

  always #HALF_PERIOD_NS o_clk = ~o_clk;

endmodule : tb_clk_gen

/* verification/tb_pingpong_buffer.sv */
// LCG stimulus, two-bank reference model, assertions, watchdog and report
`timescale 1ns/1ps

module tb_pingpong_buffer;
  import pingpong_pkg::*;

  localparam int          CLK_PERIOD_NS   = 10;
  localparam int          WATCHDOG_CYCLES = 4 * 2 * BUF_DEPTH + 1000;  // four fill+drain rounds
  localparam logic [31:0] SEED            = 32'h7980_d560;

  logic  clk;
  logic  rst_n;
  logic  en;
  logic  switch_pp;
  pix_t  din;
  logic  din_vld;
  addr_t conv_addr;
  logic  buf_ready;
  pix_t  conv_dout;

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////
  pix_t      model_mem   [NUM_BANKS][BUF_DEPTH];  // what each bank should hold
  bit        model_known [NUM_BANKS][BUF_DEPTH];  // word written at least once
  bank_sel_t m_fill;    // bank being filled
  addr_t     m_cnt;     // next write address
  logic      m_done;    // fill bank full
  logic      done_d1;   // ready as it should look
  logic      iss_d1;
  logic      iss_d2;    // checked read two edges back
  pix_t      exp_d1;
  pix_t      exp_d2;    // its expected word
  logic      hold_d1;
  logic      hold_d2;   // en was low at issue
  pix_t      m_out;       // output register as it should look
  logic      m_out_known; // m_out is defined

  logic [31:0] rand_state;
  int          err_cnt;
  int          errs_at_start;
  int          test_idx;
  int          tests_passed;
  int          tests_failed;

  tb_clk_gen u_clk (.o_clk(clk));

  pingpong_buffer dut (
    .i_clk_input       (clk),
    .i_rst_n           (rst_n),
    .i_en              (en),
    .i_switch_pingpong (switch_pp),
    .i_data_din        (din),
    .i_data_din_vld    (din_vld),
    .o_pl_buffer_ready (buf_ready),
    .i_conv_addr       (conv_addr),
    .o_conv_dout       (conv_dout)
  );

  function automatic logic [31:0] next_lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;  // classic 32-bit LCG constants
  endfunction

  function automatic pix_t model_read(input bank_sel_t bank, input addr_t addr);
    if (addr >= addr_t'(BUF_DEPTH)) begin
      return '0;  // past depth reads zero
    end
    return model_mem[bank][addr];
  endfunction

  function automatic logic word_known(input bank_sel_t bank, input addr_t addr);
    if (addr >= addr_t'(BUF_DEPTH)) begin
      return 1'b1;
    end
    return model_known[bank][addr];  // unwritten words have no defined value
  endfunction

  ////////////////////////////////////////
  // model steps once per edge
  ////////////////////////////////////////
  always @(posedge clk) begin
    bank_sel_t drain;
    drain = ~m_fill;
    if (!rst_n) begin
      m_fill      <= '0;
      m_cnt       <= '0;
      m_done      <= 1'b0;
      done_d1     <= 1'b0;
      iss_d1      <= 1'b0;
      iss_d2      <= 1'b0;
      hold_d1     <= 1'b0;
      hold_d2     <= 1'b0;
      m_out       <= '0;
      m_out_known <= 1'b1;
    end else begin
      done_d1 <= m_done;
      iss_d1  <= en && word_known(drain, conv_addr);  // bank and range fixed at issue
      exp_d1  <= model_read(drain, conv_addr);
      hold_d1 <= !en;
      iss_d2  <= iss_d1;
      exp_d2  <= exp_d1;
      hold_d2 <= hold_d1;
      if (!hold_d1) begin
        m_out       <= exp_d1;  // output follows a launched read
        m_out_known <= iss_d1;
      end
      if (en && switch_pp) begin
        m_fill <= ~m_fill;  // swap wins over a pixel
        m_cnt  <= '0;
        m_done <= 1'b0;
      end else if (en && din_vld && !m_done) begin
        model_mem[m_fill][m_cnt]   <= din;
        model_known[m_fill][m_cnt] <= 1'b1;
        m_cnt                      <= m_cnt + addr_t'(1);
        if (m_cnt + addr_t'(1) == addr_t'(BUF_DEPTH)) begin
          m_done <= 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    iss_d2 |-> (conv_dout == exp_d2))
    else begin
      err_cnt++;
      $display("Mismatch o_conv_dout: expected 0x%02h, got 0x%02h at %0t",
               $sampled(exp_d2), $sampled(conv_dout), $time);
    end

  a_read_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (hold_d2 && m_out_known) |-> (conv_dout == m_out))
    else begin
      err_cnt++;
      $display("Mismatch o_conv_dout: expected 0x%02h (held), got 0x%02h at %0t",
               $sampled(m_out), $sampled(conv_dout), $time);
    end

  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    buf_ready == done_d1)
    else begin
      err_cnt++;
      $display("Mismatch o_pl_buffer_ready: expected 0x%0h, got 0x%0h at %0t",
               $sampled(done_d1), $sampled(buf_ready), $time);
    end

  ////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////
  task automatic write_pixels(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      rand_state = next_lcg(rand_state);
      din        = rand_state[23:16];  // upper bits mix better
      din_vld    = 1'b1;
    end
    @(negedge clk);
    din_vld = 1'b0;
  endtask

  task automatic read_addresses(input int first, input int last);
    for (int a = first; a <= last; a++) begin
      @(negedge clk);
      conv_addr = addr_t'(a);  // back to back
    end
  endtask

  task automatic fill_and_drain(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      rand_state = next_lcg(rand_state);
      din        = rand_state[23:16];
      din_vld    = 1'b1;
      conv_addr  = addr_t'(i);  // drain other bank in lockstep
    end
    @(negedge clk);
    din_vld = 1'b0;
  endtask

  task automatic strobe_switch();
    @(negedge clk);
    switch_pp = 1'b1;
    @(negedge clk);
    switch_pp = 1'b0;
  endtask

  task automatic wait_for_ready(input int max_cycles);
    int n;
    n = 0;
    while (buf_ready !== 1'b1 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (buf_ready !== 1'b1) begin
      err_cnt++;
      $display("ready flag did not rise within %0d cycles", max_cycles);
    end
  endtask

  task automatic close_test(input string name);
    int errs;
    repeat (3) @(negedge clk);  // let the read pipeline reach the checks
    errs = err_cnt - errs_at_start;
    test_idx++;
    if (errs == 0) begin
      tests_passed++;
      $display("test %0d %s: pass", test_idx, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", test_idx, name, errs);
    end
    errs_at_start = err_cnt;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial begin
    rst_n         = 1'b0;
    en            = 1'b0;
    switch_pp     = 1'b0;
    din           = '0;
    din_vld       = 1'b0;
    conv_addr     = '0;
    rand_state    = SEED;
    err_cnt       = 0;
    errs_at_start = 0;
    test_idx      = 0;
    tests_passed  = 0;
    tests_failed  = 0;

    repeat (3) @(negedge clk);  // three reset edges
    rst_n = 1'b1;
    en    = 1'b1;
    assert (buf_ready == 1'b0) else begin
      err_cnt++;
      $display("Mismatch o_pl_buffer_ready: expected 0x0, got 0x%0h", buf_ready);
    end
    assert (conv_dout == '0) else begin
      err_cnt++;
      $display("Mismatch o_conv_dout: expected 0x00, got 0x%02h", conv_dout);
    end
    close_test("reset values");

    write_pixels(BUF_DEPTH);  // fill bank 0
    wait_for_ready(8);
    write_pixels(1);          // lands on a full bank
    close_test("fill bank 0");

    strobe_switch();
    read_addresses(0, BUF_DEPTH - 1);
    close_test("drain bank 0");

    fill_and_drain(BUF_DEPTH);  // bank 1 in, bank 0 out
    wait_for_ready(8);
    @(negedge clk);
    conv_addr = addr_t'(5);     // issued on bank 0
    @(negedge clk);
    conv_addr = addr_t'(6);
    switch_pp = 1'b1;           // swap right behind it
    @(negedge clk);
    switch_pp = 1'b0;
    read_addresses(0, BUF_DEPTH - 1);
    close_test("overlap fill and drain");

    read_addresses(BUF_DEPTH, 1023);
    close_test("out of range reads");

    strobe_switch();
    @(negedge clk);
    en = 1'b0;
    for (int i = 0; i < BUF_DEPTH; i++) begin
      @(negedge clk);
      rand_state = next_lcg(rand_state);
      din        = rand_state[23:16];
      din_vld    = 1'b1;
      conv_addr  = addr_t'(i);  // must not launch reads
    end
    @(negedge clk);
    din_vld = 1'b0;
    assert (buf_ready == 1'b0) else begin
      err_cnt++;
      $display("Mismatch o_pl_buffer_ready: expected 0x0, got 0x%0h", buf_ready);
    end
    en = 1'b1;
    @(negedge clk);
    rand_state = next_lcg(rand_state);
    din        = rand_state[23:16];
    din_vld    = 1'b1;
    switch_pp  = 1'b1;  // pixel dropped as the swap wins
    @(negedge clk);
    din_vld   = 1'b0;
    switch_pp = 1'b0;
    write_pixels(16);   // should start at address 0
    strobe_switch();
    read_addresses(0, 15);
    close_test("enable gating and switch priority");

    $display("tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
             err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule : tb_pingpong_buffer

/* sim.f */
src/pingpong_pkg.sv
src/bank_if.sv
src/input_pre_sram.sv
src/pingpong_fill_ctrl.sv
src/pingpong_drain_reader.sv
src/pingpong_buffer.sv
verification/tb_clk_gen.sv
verification/tb_pingpong_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the ping-pong buffer testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_pingpong_buffer \
  -f sim.f -o tb_pingpong_buffer > "$BUILD_LOG" 2>&1 \
  || { cat "$BUILD_LOG"; echo "build failed, see $BUILD_LOG"; exit 1; }

./obj_dir/tb_pingpong_buffer > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

# a run without any verdict line counts as broken
grep -q "Simulation FAILED" "$SIM_LOG" && { echo "run failed, see $SIM_LOG"; exit 1; }
grep -q "Simulation PASSED" "$SIM_LOG" || { echo "run ended without a verdict"; exit 1; }
exit 0
